// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN      = 64;  // rv64
    localparam int ILEN      = 32;  // no compressed forms
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [ILEN-1:0]      inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // major opcodes kept by the core, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,  // addiw, slliw, srliw, sraiw
        OP_OP     = 7'b0110011,
        OP_32     = 7'b0111011   // addw, subw, sllw, srlw, sraw
    } opcode_e;

    // funct3 of the integer groups
    localparam logic [2:0] F3_ADD  = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl or sra by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    // branch funct3, 010 and 011 unused
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_e;

endpackage

// File: src/rv_bus_pkg.sv
package rv_bus_pkg;

    localparam int BUS_ADDR_W = 64;
    localparam int BUS_DATA_W = 64;

    // access size on the data bus, coded as the load/store funct3
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,  // unsigned forms, loads only
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } mem_size_e;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_isa_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,        // async, active low
    input  logic  full_i,
    input  logic  redirect_i,
    input  xlen_t target_i,
    input  inst_t imem_data_i,  // same cycle as the address
    output xlen_t imem_addr_o,
    output logic  push_o,
    output xlen_t push_pc_o,
    output inst_t push_inst_o
);

    xlen_t pc_q;

    assign imem_addr_o = pc_q;
    assign push_o      = !full_i && !redirect_i;  // word behind a redirect is stale
    assign push_pc_o   = pc_q;
    assign push_inst_o = imem_data_i;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;      // jump or taken branch
        end else if (push_o) begin
            pc_q <= pc_q + 64'd4;
        end
        // queue full, pc holds
    end

    // exec unit must only send word aligned targets
    a_target_aligned: assert property (
        @(posedge clk) disable iff (!reset) redirect_i |-> target_i[1:0] == 2'b00
    );

endmodule

// File: src/inst_queue.sv
`timescale 1ns/1ps

module inst_queue import rv_isa_pkg::*; #(
    parameter int QUEUE_DEPTH = 2  // power of two
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush_i,
    input  logic  push_i,
    input  xlen_t push_pc_i,
    input  inst_t push_inst_i,
    input  logic  pop_i,
    output logic  full_o,
    output logic  valid_o,
    output xlen_t head_pc_o,
    output inst_t head_inst_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    xlen_t            pc_mem   [QUEUE_DEPTH];
    inst_t            inst_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;  // one bit wider to hold QUEUE_DEPTH

    assign full_o      = count_q == (PTR_W+1)'(QUEUE_DEPTH);
    assign valid_o     = count_q != '0;
    assign head_pc_o   = pc_mem[rd_ptr_q];
    assign head_inst_o = inst_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_ptr_q]   <= push_pc_i;
            inst_mem[wr_ptr_q] <= push_inst_i;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;  // flush drops all words fetched past a redirect
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_i);   // pointers wrap on their own
            wr_ptr_q <= wr_ptr_q + PTR_W'(push_i);
            count_q  <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
        end
    end

    // handshake rules owed by fetch and exec
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!reset) push_i |-> !full_o
    );
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!reset) pop_i |-> valid_o
    );

endmodule

// File: src/int_alu.sv
`timescale 1ns/1ps

module int_alu import rv_isa_pkg::*; (
    input  alu_op_e op_i,
    input  logic    word_i,  // W variant, 32-bit result sign extended
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  branch_e br_i,
    output xlen_t   result_o,
    output logic    taken_o
);

    xlen_t       res64;
    logic [31:0] res32;

    always_comb begin
        case (op_i)
            ALU_ADD:  res64 = a_i + b_i;
            ALU_SUB:  res64 = a_i - b_i;
            ALU_XOR:  res64 = a_i ^ b_i;
            ALU_OR:   res64 = a_i | b_i;
            ALU_AND:  res64 = a_i & b_i;
            ALU_SLL:  res64 = a_i << b_i[5:0];  // 6-bit shamt on rv64
            ALU_SRL:  res64 = a_i >> b_i[5:0];
            ALU_SRA:  res64 = $signed(a_i) >>> b_i[5:0];
            ALU_SLT:  res64 = {63'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: res64 = {63'b0, a_i < b_i};
            default:  res64 = '0;
        endcase
    end

    // word forms see only the low half and a 5-bit shamt
    always_comb begin
        case (op_i)
            ALU_SUB: res32 = a_i[31:0] - b_i[31:0];
            ALU_SLL: res32 = a_i[31:0] << b_i[4:0];
            ALU_SRL: res32 = a_i[31:0] >> b_i[4:0];
            ALU_SRA: res32 = $signed(a_i[31:0]) >>> b_i[4:0];
            default: res32 = res64[31:0];  // addw, low half of the sum
        endcase
    end

    assign result_o = word_i ? {{32{res32[31]}}, res32} : res64;

    always_comb begin
        case (br_i)
            BR_EQ:   taken_o = a_i == b_i;
            BR_NE:   taken_o = a_i != b_i;
            BR_LT:   taken_o = $signed(a_i) < $signed(b_i);
            BR_GE:   taken_o = $signed(a_i) >= $signed(b_i);
            BR_LTU:  taken_o = a_i < b_i;
            BR_GEU:  taken_o = a_i >= b_i;
            default: taken_o = 1'b0;  // reserved funct3, falls through
        endcase
    end

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import rv_isa_pkg::*, rv_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_load_i,
    input  logic                  start_store_i,
    input  xlen_t                 base_i,
    input  xlen_t                 offset_i,
    input  xlen_t                 store_data_i,
    input  mem_size_e             size_i,
    input  logic [BUS_DATA_W-1:0] bus_rdata_i,
    input  logic                  bus_read_done_i,
    input  logic                  bus_write_done_i,
    output logic                  busy_o,
    output logic                  load_done_o,
    output xlen_t                 load_data_o,
    output logic [BUS_ADDR_W-1:0] bus_addr_o,
    output logic [BUS_DATA_W-1:0] bus_wdata_o,
    output mem_size_e             bus_size_o,
    output logic                  bus_read_enable_o,
    output logic                  bus_write_enable_o
);

    assign busy_o      = bus_read_enable_o || bus_write_enable_o;
    assign load_done_o = bus_read_enable_o && bus_read_done_i;  // rd written this edge

    // request captured once, held for the whole handshake
    always_ff @(posedge clk) begin
        if (start_load_i || start_store_i) begin
            bus_addr_o  <= base_i + offset_i;
            bus_wdata_o <= store_data_i;  // whole rs2, size picks the bytes
            bus_size_o  <= size_i;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bus_read_enable_o  <= 1'b0;
            bus_write_enable_o <= 1'b0;
        end else begin
            if (start_load_i) begin
                bus_read_enable_o <= 1'b1;
            end else if (bus_read_done_i) begin
                bus_read_enable_o <= 1'b0;  // drops at the done edge
            end
            if (start_store_i) begin
                bus_write_enable_o <= 1'b1;
            end else if (bus_write_done_i) begin
                bus_write_enable_o <= 1'b0;
            end
        end
    end

    // slave returns the item in the low lanes
    always_comb begin
        case (bus_size_o)
            MEM_B:   load_data_o = {{56{bus_rdata_i[7]}}, bus_rdata_i[7:0]};
            MEM_H:   load_data_o = {{48{bus_rdata_i[15]}}, bus_rdata_i[15:0]};
            MEM_W:   load_data_o = {{32{bus_rdata_i[31]}}, bus_rdata_i[31:0]};
            MEM_D:   load_data_o = bus_rdata_i;
            MEM_BU:  load_data_o = {56'b0, bus_rdata_i[7:0]};
            MEM_HU:  load_data_o = {48'b0, bus_rdata_i[15:0]};
            MEM_WU:  load_data_o = {32'b0, bus_rdata_i[31:0]};
            default: load_data_o = bus_rdata_i;
        endcase
    end

    // slave may sample on any cycle until it answers, exec must not restart early
    a_req_stable: assert property (
        @(posedge clk) disable iff (!reset)
        (bus_read_enable_o && !bus_read_done_i) || (bus_write_enable_o && !bus_write_done_i)
        |=> $stable(bus_addr_o) && $stable(bus_size_o) && $stable(bus_wdata_o)
    );

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import rv_isa_pkg::*, rv_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_i,
    input  xlen_t                 pc_i,
    input  inst_t                 inst_i,
    input  logic [BUS_DATA_W-1:0] bus_rdata_i,
    input  logic                  bus_read_done_i,
    input  logic                  bus_write_done_i,
    output logic                  pop_o,
    output logic                  redirect_o,
    output xlen_t                 target_o,
    output logic [BUS_ADDR_W-1:0] bus_addr_o,
    output logic [BUS_DATA_W-1:0] bus_wdata_o,
    output mem_size_e             bus_size_o,
    output logic                  bus_read_enable_o,
    output logic                  bus_write_enable_o
);

    opcode_e  opcode;
    xlen_t    regs [32];  // x0 slot never read
    reg_idx_t ld_rd_q;    // rd of the outstanding load
    xlen_t    alu_res;
    xlen_t    wb_data;
    xlen_t    load_data;
    alu_op_e  alu_op;
    logic     wb_en;
    logic     taken;
    logic     lsu_busy;
    logic     load_done;

    wire [2:0]     funct3 = inst_i[14:12];
    wire reg_idx_t rd     = inst_i[11:7];
    wire reg_idx_t rs1    = inst_i[19:15];
    wire reg_idx_t rs2    = inst_i[24:20];

    wire xlen_t imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
    wire xlen_t imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    wire xlen_t imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    wire xlen_t imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    wire xlen_t imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    wire xlen_t rs1_val = (rs1 == '0) ? '0 : regs[rs1];  // x0 reads zero
    wire xlen_t rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    wire reg_form = opcode == OP_OP || opcode == OP_32;  // rs2 operand
    wire is_alu   = reg_form || opcode == OP_IMM || opcode == OP_IMM_32;
    wire alt      = inst_i[31:26] == F7_ALT[6:1];       // bit 25 is shamt[5] on imm shifts
    wire f7_ok    = !reg_form || inst_i[31:25] == '0 || inst_i[31:25] == F7_ALT;
    wire is_load  = opcode == OP_LOAD && funct3 != 3'b111;
    wire is_store = opcode == OP_STORE && !funct3[2];

    wire xlen_t alu_a = (opcode == OP_AUIPC) ? pc_i : rs1_val;
    wire xlen_t alu_b = (reg_form || opcode == OP_BRANCH) ? rs2_val :
                        (opcode == OP_AUIPC)              ? imm_u   : imm_i;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign pop_o  = valid_i && !lsu_busy;  // head waits while an access is out

    always_comb begin
        alu_op = ALU_ADD;  // auipc, jalr sums
        if (is_alu) begin
            case (funct3)
                F3_ADD:  alu_op = (reg_form && alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OP_LUI:          wb_data = imm_u;
            OP_JAL, OP_JALR: wb_data = pc_i + 64'd4;  // link
            default:         wb_data = alu_res;
        endcase
    end

    // branch, store, unknown: no write, load writes later
    assign wb_en = pop_o && rd != '0 && f7_ok &&
                   (is_alu || opcode inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR});

    always_comb begin
        case (opcode)
            OP_JAL:  target_o = pc_i + imm_j;
            OP_JALR: target_o = {alu_res[63:1], 1'b0};  // rs1 + imm, bit 0 cleared
            default: target_o = pc_i + imm_b;
        endcase
    end

    assign redirect_o = pop_o &&
                        (opcode inside {OP_JAL, OP_JALR} || (opcode == OP_BRANCH && taken));

    always_ff @(posedge clk) begin
        if (wb_en) begin
            regs[rd] <= wb_data;
        end
        if (load_done && ld_rd_q != '0) begin
            regs[ld_rd_q] <= load_data;  // at the read done edge
        end
        if (pop_o && is_load) begin
            ld_rd_q <= rd;
        end
    end

    int_alu int_alu_i (
        .op_i     (alu_op),
        .word_i   (opcode == OP_IMM_32 || opcode == OP_32),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .br_i     (branch_e'(funct3)),
        .result_o (alu_res),
        .taken_o  (taken)
    );

    load_store_unit load_store_unit_i (
        .clk                (clk),
        .reset              (reset),
        .start_load_i       (pop_o && is_load),
        .start_store_i      (pop_o && is_store),
        .base_i             (rs1_val),
        .offset_i           (is_store ? imm_s : imm_i),
        .store_data_i       (rs2_val),
        .size_i             (mem_size_e'(funct3)),
        .bus_rdata_i        (bus_rdata_i),
        .bus_read_done_i    (bus_read_done_i),
        .bus_write_done_i   (bus_write_done_i),
        .busy_o             (lsu_busy),
        .load_done_o        (load_done),
        .load_data_o        (load_data),
        .bus_addr_o         (bus_addr_o),
        .bus_wdata_o        (bus_wdata_o),
        .bus_size_o         (bus_size_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_write_enable_o (bus_write_enable_o)
    );

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, rv_bus_pkg::*; #(
    parameter xlen_t RESET_PC    = '0,
    parameter int    QUEUE_DEPTH = 2   // power of two, at least 2
) (
    input  logic      clk,
    input  logic      reset,           // async, active low
    input  inst_t     imem_data_i,
    input  xlen_t     bus_rdata_i,
    input  logic      bus_read_done_i,
    input  logic      bus_write_done_i,
    output xlen_t     imem_addr_o,
    output xlen_t     bus_addr_o,
    output xlen_t     bus_wdata_o,
    output mem_size_e bus_size_o,
    output logic      bus_read_enable_o,
    output logic      bus_write_enable_o
);

    logic  full;
    logic  push;
    xlen_t push_pc;
    inst_t push_inst;
    logic  valid;
    xlen_t head_pc;
    inst_t head_inst;
    logic  pop;
    logic  redirect;  // reloads pc and flushes the queue
    xlen_t target;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_i (
        .clk         (clk),
        .reset       (reset),
        .full_i      (full),
        .redirect_i  (redirect),
        .target_i    (target),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .push_o      (push),
        .push_pc_o   (push_pc),
        .push_inst_o (push_inst)
    );

    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_i (
        .clk         (clk),
        .reset       (reset),
        .flush_i     (redirect),
        .push_i      (push),
        .push_pc_i   (push_pc),
        .push_inst_i (push_inst),
        .pop_i       (pop),
        .full_o      (full),
        .valid_o     (valid),
        .head_pc_o   (head_pc),
        .head_inst_o (head_inst)
    );

    exec_unit exec_unit_i (
        .clk                (clk),
        .reset              (reset),
        .valid_i            (valid),
        .pc_i               (head_pc),
        .inst_i             (head_inst),
        .bus_rdata_i        (bus_rdata_i),
        .bus_read_done_i    (bus_read_done_i),
        .bus_write_done_i   (bus_write_done_i),
        .pop_o              (pop),
        .redirect_o         (redirect),
        .target_o           (target),
        .bus_addr_o         (bus_addr_o),
        .bus_wdata_o        (bus_wdata_o),
        .bus_size_o         (bus_size_o),
        .bus_read_enable_o  (bus_read_enable_o),
        .bus_write_enable_o (bus_write_enable_o)
    );

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [11:0] DONE_ADDR = 12'h7F8;  // end of program marker

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic [63:0] bus_rdata;
    logic        bus_read_done;
    logic        bus_write_done;
    logic [63:0] imem_addr;
    logic [63:0] bus_addr;
    logic [63:0] bus_wdata;
    logic [2:0]  bus_size;
    logic        bus_read_enable;
    logic        bus_write_enable;

    logic [31:0] imem [256];
    logic [7:0]  dmem [8192];
    logic [63:0] st_addr_q [$];  // every store seen on the bus
    logic [2:0]  st_size_q [$];
    integer      seed;
    int          pc_n;           // next free word in imem
    int          delay;
    bit          pending;
    bit          done_seen;

    rv_core #(.RESET_PC(64'h0), .QUEUE_DEPTH(2)) rv_core_i (
        .clk                (clk),
        .reset              (reset),
        .imem_data_i        (imem_data),
        .bus_rdata_i        (bus_rdata),
        .bus_read_done_i    (bus_read_done),
        .bus_write_done_i   (bus_write_done),
        .imem_addr_o        (imem_addr),
        .bus_addr_o         (bus_addr),
        .bus_wdata_o        (bus_wdata),
        .bus_size_o         (bus_size),
        .bus_read_enable_o  (bus_read_enable),
        .bus_write_enable_o (bus_write_enable)
    );

    assign imem_data = imem[imem_addr[9:2]];  // combinational read

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fill byte mixes every address bit
    function automatic logic [7:0] pattern(input logic [12:0] a);
        return a[7:0] ^ a[12:5];
    endfunction

    function automatic logic [63:0] rd64(input logic [12:0] a);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = dmem[13'(a + 13'(i))];
        return v;
    endfunction

    // data bus slave answering after 0 to 3 cycles
    always @(posedge clk or negedge reset) begin
        if (!reset) begin
            pending = 1'b0;
            bus_read_done <= 1'b0;
            bus_write_done <= 1'b0;
        end else begin
            bus_read_done <= 1'b0;
            bus_write_done <= 1'b0;
            if (!pending && !bus_read_done && !bus_write_done &&
                (bus_read_enable || bus_write_enable)) begin
                pending = 1'b1;
                delay = $random(seed) & 3;
            end
            if (pending && delay == 0) begin
                pending = 1'b0;
                if (bus_write_enable) begin
                    for (int i = 0; i < (1 << bus_size[1:0]); i++)
                        dmem[13'(bus_addr[12:0] + 13'(i))] = bus_wdata[8*i +: 8];
                    st_addr_q.push_back(bus_addr);
                    st_size_q.push_back(bus_size);
                    if (bus_addr == 64'(DONE_ADDR)) done_seen = 1'b1;
                    bus_write_done <= 1'b1;
                end else begin
                    bus_rdata <= rd64(bus_addr[12:0]);  // item in the low lanes
                    bus_read_done <= 1'b1;
                end
            end else if (pending) begin
                delay--;
            end
        end
    end

    task automatic fail(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            fail("value mismatch");
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {f7, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6F};
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[pc_n] = w;
        pc_n++;
    endtask

    task automatic new_program();
        pc_n = 0;
        for (int i = 0; i < 256; i++) imem[i] = 32'h13;  // addi x0 as nop
        for (int i = 0; i < 8192; i++) dmem[i] = pattern(13'(i));
    endtask

    task automatic put64(input logic [12:0] a, input logic [63:0] v);
        for (int i = 0; i < 8; i++) dmem[13'(a + 13'(i))] = v[8*i +: 8];
    endtask

    // reset with state checks then run until the marker store
    task automatic run_program();
        int n;
        emit(enc_s(DONE_ADDR, 0, 0, 3));
        emit(enc_j(21'd0, 0));  // park
        done_seen = 1'b0;
        st_addr_q.delete();
        st_size_q.delete();
        @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check(64'(bus_read_enable), 64'd0, "read enable in reset");
            check(64'(bus_write_enable), 64'd0, "write enable in reset");
            check(imem_addr, 64'h0, "pc in reset");
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check(imem_addr, 64'h0, "pc after reset");
        check(64'(bus_read_enable), 64'd0, "read enable after reset");
        check(64'(bus_write_enable), 64'd0, "write enable after reset");
        n = 0;
        while (!done_seen && n < 3000) begin
            @(posedge clk);
            n++;
        end
        if (!done_seen) fail("timeout: program never stored its end marker");
        @(negedge clk);
    endtask

    // rv64i semantics of the integer groups
    function automatic logic [63:0] alu_model(int f3, bit alt, bit word, logic [63:0] a,
                                              logic [63:0] b);
        logic [31:0] w;
        if (word) begin
            case (f3)
                0:       w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                1:       w = a[31:0] << b[4:0];
                default: w = alt ? 32'($signed(a[31:0]) >>> b[4:0]) : a[31:0] >> b[4:0];
            endcase
            return {{32{w[31]}}, w};
        end
        case (f3)
            0:       return alt ? a - b : a + b;
            1:       return a << b[5:0];
            2:       return 64'($signed(a) < $signed(b));
            3:       return 64'(a < b);
            4:       return a ^ b;
            5:       return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic int_ops(input bit word, input logic [63:0] a, input logic [63:0] b);
        logic [63:0] exp_q [$];
        logic [11:0] imm;
        logic [63:0] bval;
        bit          shift;
        new_program();
        put64(13'h100, a);
        put64(13'h108, b);
        emit(enc_i(12'h100, 0, 3, 1, 7'h03));  // ld x1
        emit(enc_i(12'h108, 0, 3, 2, 7'h03));  // ld x2
        for (int rr = 0; rr < 2; rr++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    shift = f3 == 1 || f3 == 5;
                    if (alt == 1 && f3 != 0 && f3 != 5) continue;
                    if (alt == 1 && f3 == 0 && rr == 0) continue;  // no subi
                    if (word && f3 != 0 && !shift) continue;
                    if (rr == 1) begin
                        emit(enc_r(alt ? 7'h20 : 7'h00, 2, 1, f3, 3, word ? 7'h3B : 7'h33));
                        bval = b;
                    end else begin
                        imm = shift ? {1'b0, alt[0], 4'b0, word ? 6'd13 : 6'd45} : 12'hF2D;
                        emit(enc_i(imm, 1, f3, 3, word ? 7'h1B : 7'h13));
                        bval = shift ? 64'(imm[5:0]) : {{52{imm[11]}}, imm};
                    end
                    emit(enc_s(12'(12'h200 + 8 * exp_q.size()), 3, 0, 3));
                    exp_q.push_back(alu_model(f3, alt[0], word, a, bval));
                end
            end
        end
        run_program();
        for (int i = 0; i < exp_q.size(); i++)
            check(rd64(13'(13'h200 + 8 * i)), exp_q[i], $sformatf("alu result %0d", i));
    endtask

    task automatic branch_case(input int f3, input logic [63:0] a, input logic [63:0] b);
        bit taken;
        case (f3)
            0:       taken = a == b;
            1:       taken = a != b;
            4:       taken = $signed(a) < $signed(b);
            5:       taken = $signed(a) >= $signed(b);
            6:       taken = a < b;
            default: taken = a >= b;
        endcase
        new_program();
        put64(13'h100, a);
        put64(13'h108, b);
        emit(enc_i(12'h100, 0, 3, 1, 7'h03));
        emit(enc_i(12'h108, 0, 3, 2, 7'h03));
        emit(enc_b(13'd12, 2, 1, f3));            // pc 8 branches to 20
        emit(enc_s(12'h300, 1, 0, 3));            // pc 12 fall-through path
        emit(enc_j(21'd12, 5));                   // pc 16 jumps to 28
        emit(enc_s(12'h308, 2, 0, 3));            // pc 20 taken path
        emit(enc_j(21'd4, 5));                    // pc 24 jumps to 28
        emit(enc_i(12'd40, 0, 0, 8, 7'h13));      // pc 28 sets x8 to 40
        emit(enc_i(12'd1, 8, 0, 7, 7'h67));       // pc 32 jalr drops bit 0
        emit(enc_s(12'h310, 0, 0, 3));            // pc 36 never runs
        emit(enc_s(12'h318, 5, 0, 3));
        emit(enc_s(12'h320, 7, 0, 3));
        run_program();
        check(64'(st_addr_q.size()), 64'd4, "stores on the bus");
        check(st_addr_q[0], taken ? 64'h308 : 64'h300, "path store address");
        check(rd64(13'h300), taken ? rd64pat(13'h300) : a, "fall-through store");
        check(rd64(13'h308), taken ? b : rd64pat(13'h308), "taken store");
        check(rd64(13'h310), rd64pat(13'h310), "store after jalr");
        check(rd64(13'h318), taken ? 64'd28 : 64'd20, "jal link");
        check(rd64(13'h320), 64'd36, "jalr link");
    endtask

    function automatic logic [63:0] rd64pat(input logic [12:0] a);
        logic [63:0] v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = pattern(13'(a + 13'(i)));
        return v;
    endfunction

    task automatic mem_ops();
        logic [63:0] v;
        logic [63:0] e;
        logic [12:0] sa;
        v = 64'hF1E2_D3C4_B5A6_9788;  // sign bits set in every lane
        new_program();
        put64(13'h140, v);
        emit(enc_i(12'h140, 0, 0, 9, 7'h13));  // x9 = base
        for (int sz = 0; sz < 7; sz++) begin
            emit(enc_i(12'h0, 9, sz, 3, 7'h03));
            emit(enc_s(12'(12'h400 + 8 * sz), 3, 0, 3));
        end
        emit(enc_i(12'h140, 0, 3, 4, 7'h03));
        for (int sz = 0; sz < 4; sz++) emit(enc_s(12'(12'h480 + 24 * sz), 4, 0, sz));
        run_program();
        for (int sz = 0; sz < 7; sz++) begin
            case (sz)
                0:       e = {{56{v[7]}}, v[7:0]};
                1:       e = {{48{v[15]}}, v[15:0]};
                2:       e = {{32{v[31]}}, v[31:0]};
                3:       e = v;
                4:       e = 64'(v[7:0]);
                5:       e = 64'(v[15:0]);
                default: e = 64'(v[31:0]);
            endcase
            check(rd64(13'(13'h400 + 8 * sz)), e, $sformatf("load size %0d", sz));
        end
        for (int sz = 0; sz < 4; sz++) begin
            sa = 13'(13'h480 + 24 * sz);  // 0x480 0x498 0x4b0 0x4c8 all double aligned
            check(st_addr_q[7 + sz], 64'(sa), "store address");
            check(64'(st_size_q[7 + sz]), 64'(sz), "store size code");
            check(64'(dmem[13'(sa - 13'd1)]), 64'(pattern(13'(sa - 13'd1))), "byte below");
            for (int i = 0; i < (1 << sz); i++)
                check(64'(dmem[13'(sa + 13'(i))]), 64'(v[8*i +: 8]), "stored byte");
            check(64'(dmem[13'(sa + 13'(1 << sz))]), 64'(pattern(13'(sa + 13'(1 << sz)))),
                  "byte above");
        end
    endtask

    initial begin
        logic [63:0] pairs_a [3];
        logic [63:0] pairs_b [3];
        int          kinds [6];
        seed = 32'ha6dc6cb6;
        reset = 1'b0;
        bus_rdata = '0;
        bus_read_done = 1'b0;
        bus_write_done = 1'b0;
        done_seen = 1'b0;
        pending = 1'b0;
        int_ops(1'b0, -64'sd5, 64'd3);
        int_ops(1'b0, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
        int_ops(1'b1, 64'h0000_0001_8765_4321, 64'h8000_0013_F000_000D);
        int_ops(1'b1, {$random(seed), $random(seed)} | 64'h8000_0000,
                {$random(seed), $random(seed)});
        pairs_a = '{-64'sd1, 64'd1, 64'd7};
        pairs_b = '{64'd1, -64'sd1, 64'd7};
        kinds = '{0, 1, 4, 5, 6, 7};
        foreach (kinds[k])
            for (int p = 0; p < 3; p++) branch_case(kinds[k], pairs_a[p], pairs_b[p]);
        mem_ops();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: rv_core.f
src/rv_isa_pkg.sv
src/rv_bus_pkg.sv
src/fetch_unit.sv
src/inst_queue.sv
src/int_alu.sv
src/load_store_unit.sv
src/exec_unit.sv
src/rv_core.sv
verification/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -o sim_rv_core; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/sim_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
